// ==== logic/isaPkg.sv ====
`default_nettype none

package isaPkg;

    localparam int dataWidth = 32;                     // Machine word

    typedef logic [dataWidth-1:0] word_t;              // Data and address word
    typedef logic [4:0]           regIdx_t;            // One of 32 registers
    typedef logic [5:0]           opcode_t;            // Primary opcode field
    typedef logic [5:0]           funct_t;             // R-type function field

    // Opcodes of the supported subset
    localparam opcode_t opR    = 6'b000000;            // All R-type, funct decides
    localparam opcode_t opJ    = 6'b000010;            // Jump
    localparam opcode_t opBeq  = 6'b000100;            // Branch on equal
    localparam opcode_t opBne  = 6'b000101;            // Branch on not equal
    localparam opcode_t opAddi = 6'b001000;            // Add immediate
    localparam opcode_t opLw   = 6'b100011;            // Load word
    localparam opcode_t opSw   = 6'b101011;            // Store word

    // Funct codes under opR
    localparam funct_t fnAdd = 6'b100000;
    localparam funct_t fnSub = 6'b100010;
    localparam funct_t fnAnd = 6'b100100;
    localparam funct_t fnOr  = 6'b100101;
    localparam funct_t fnSlt = 6'b101010;

    // One fetched word, three ways to slice it
    typedef union packed {
        struct packed {
            opcode_t    opcode;                        // [31:26]
            regIdx_t    rs;                            // [25:21] first source
            regIdx_t    rt;                            // [20:16] second source
            regIdx_t    rd;                            // [15:11] destination
            logic [4:0] shamt;                         // Not used by this subset
            funct_t     funct;                         // [5:0]
        } rType;
        struct packed {
            opcode_t     opcode;
            regIdx_t     rs;                           // Base or first operand
            regIdx_t     rt;                           // Destination or second operand
            logic [15:0] imm;                          // Signed offset or constant
        } iType;
        struct packed {
            opcode_t     opcode;
            logic [25:0] target;                       // Word index inside 256 MB region
        } jType;
    } instr_t;

    localparam word_t pcStep = 32'd4;                  // Bytes per instruction

endpackage

`default_nettype wire

// ==== logic/aluPkg.sv ====
`default_nettype none

package aluPkg;

    // Bit 2 set means invert B and carry in one
    typedef enum logic [2:0] {
        aluAnd = 3'b000,
        aluOr  = 3'b001,
        aluAdd = 3'b010,
        aluSub = 3'b110,
        aluSlt = 3'b111                                // Subtract, then keep sign only
    } aluOp_t;

    localparam int sliceWidth = 4;                     // Bits per lookahead slice
    localparam int sliceCount = isaPkg::dataWidth / sliceWidth; // Rippled slices, 8

endpackage

`default_nettype wire

// ==== logic/aluSlice4.sv ====
`default_nettype none

module aluSlice4
    import aluPkg::*;
(
    input  logic [sliceWidth-1:0] a,
    input  logic [sliceWidth-1:0] b,
    input  aluOp_t                op,
    input  logic                  cin,                 // Ripple from lower slice
    input  logic                  less,                // Set value, lowest slice only
    output logic [sliceWidth-1:0] result,
    output logic                  cout,
    output logic                  msbSum               // Sum of top bit, sign for slt
);

    logic [sliceWidth-1:0] bEff;                       // B after optional invert
    logic [sliceWidth-1:0] g;                          // Generate per bit
    logic [sliceWidth-1:0] p;                          // Propagate per bit
    logic [sliceWidth-1:0] c;                          // Carry into each bit
    logic [sliceWidth-1:0] sum;

    // One-bit cells
    for (genvar i = 0; i < sliceWidth; i++) begin : gCell
        assign bEff[i] = b[i] ^ op[2];                 // Subtract inverts B
        assign g[i]    = a[i] & bEff[i];
        assign p[i]    = a[i] | bEff[i];
        assign sum[i]  = a[i] ^ bEff[i] ^ c[i];
    end

    // Lookahead carries, no ripple inside the slice
    assign c[0] = cin;
    assign c[1] = g[0] | (p[0] & cin);
    assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
    assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & cin);
    assign cout = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0])
                | (p[3] & p[2] & p[1] & p[0] & cin);

    assign msbSum = sum[sliceWidth-1];

    always_comb begin
        case (op)
            aluAnd:         result = a & b;
            aluOr:          result = a | b;
            aluAdd, aluSub: result = sum;
            aluSlt:         result = {{(sliceWidth-1){1'b0}}, less}; // Only bit 0 carries less
            default:        result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/executeUnit.sv ====
`default_nettype none

module executeUnit
    import isaPkg::*;
    import aluPkg::*;
(
    input  word_t  rsData,
    input  word_t  rtData,
    input  instr_t instr,                              // Immediate source
    input  logic   aluSrc,
    input  aluOp_t aluOp,
    output word_t  aluResult,
    output logic   aluZero
);

    word_t                 immExt;                     // Sign-extended immediate
    word_t                 opB;
    logic [sliceCount:0]   carry;                      // Ripple between slices
    logic [sliceCount-1:0] msbSum;                     // Only the top one matters
    logic                  topBEff;                    // Top bit of B as added
    logic                  signedOvf;
    logic                  sltLess;                    // True sign of rs - rt

    assign immExt = {{16{instr.iType.imm[15]}}, instr.iType.imm};
    assign opB    = aluSrc ? immExt : rtData;

    assign carry[0] = aluOp[2];                        // +1 completes two's complement

    for (genvar i = 0; i < sliceCount; i++) begin : gSlice
        aluSlice4 slice_i (
            .a      (rsData[i*sliceWidth +: sliceWidth]),
            .b      (opB[i*sliceWidth +: sliceWidth]),
            .op     (aluOp),
            .cin    (carry[i]),
            .less   ((i == 0) ? sltLess : 1'b0),       // Set bit enters at bit 0
            .result (aluResult[i*sliceWidth +: sliceWidth]),
            .cout   (carry[i+1]),
            .msbSum (msbSum[i])
        );
    end

    // Overflow when operands agree in sign and the sum does not
    assign topBEff   = opB[dataWidth-1] ^ aluOp[2];
    assign signedOvf = (rsData[dataWidth-1] ~^ topBEff)
                     & (msbSum[sliceCount-1] ^ rsData[dataWidth-1]);
    assign sltLess   = msbSum[sliceCount-1] ^ signedOvf; // Corrected sign

    assign aluZero = (aluResult == '0);

    // Decoder always hands over a defined operation
    always_comb begin
        aluOpKnown: assert (!$isunknown(aluOp)
                            && aluOp inside {aluAnd, aluOr, aluAdd, aluSub, aluSlt})
            else $error("aluOp undefined");
    end

endmodule

`default_nettype wire

// ==== logic/programCounter.sv ====
`default_nettype none

module programCounter
    import isaPkg::*;
(
    input  logic   Clk,
    input  logic   arstN,
    input  instr_t instr,                              // Current instruction word
    input  logic   aluZero,                            // rs == rt for branches
    input  logic   beq,
    input  logic   bne,
    input  logic   jump,
    output word_t  pc,
    output logic   running                             // Low for one edge after reset
);

    word_t pcPlus4;                                    // Sequential successor
    word_t branchOffset;                               // Immediate in bytes
    word_t branchTarget;
    word_t jumpTarget;
    word_t nextPc;
    logic  branchTaken;

    assign pcPlus4      = pc + pcStep;
    assign branchOffset = {{14{instr.iType.imm[15]}}, instr.iType.imm, 2'b00}; // Sign ext times 4
    assign branchTarget = pcPlus4 + branchOffset;      // Relative to delay slot address
    assign jumpTarget   = {pcPlus4[31:28], instr.jType.target, 2'b00}; // Region of PC+4

    assign branchTaken = (beq & aluZero) | (bne & ~aluZero);

    always_comb begin
        if (jump) begin
            nextPc = jumpTarget;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    // First edge after reset only raises running and leaves PC at zero
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pc      <= '0;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (running) begin
                pc <= nextPc;                          // Retire current instruction
            end
        end
    end

    pcAligned: assert property (@(posedge Clk) disable iff (!arstN)
        pc[1:0] == 2'b00)
        else $error("pc lost word alignment");

endmodule

`default_nettype wire

// ==== logic/controlDecoder.sv ====
`default_nettype none

module controlDecoder
    import isaPkg::*;
    import aluPkg::*;
(
    input  instr_t  instr,
    input  logic    running,                           // Strobes stay off until set
    output logic    regWrite,
    output logic    memToReg,                          // Write back load data
    output logic    memWrite,
    output logic    memRead,
    output logic    aluSrc,                            // Immediate as operand B
    output logic    beq,
    output logic    bne,
    output logic    jump,
    output aluOp_t  aluOp,
    output regIdx_t writeReg
);

    logic regDst;                                      // rd for R-type, else rt
    logic regWriteDec;                                 // Ungated decode
    logic memWriteDec;
    logic memReadDec;

    always_comb begin
        regDst      = 1'b0;                            // Defaults give a no-op
        regWriteDec = 1'b0;
        memWriteDec = 1'b0;
        memReadDec  = 1'b0;
        memToReg    = 1'b0;
        aluSrc      = 1'b0;
        beq         = 1'b0;
        bne         = 1'b0;
        jump        = 1'b0;
        aluOp       = aluAdd;
        case (instr.rType.opcode)
            opR: begin
                regDst      = 1'b1;
                regWriteDec = 1'b1;
                case (instr.rType.funct)
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    default: regWriteDec = 1'b0;       // Unknown funct retires as no-op
                endcase
            end
            opAddi: begin
                aluSrc      = 1'b1;
                regWriteDec = 1'b1;
            end
            opLw: begin
                aluSrc      = 1'b1;                    // Base plus offset
                memReadDec  = 1'b1;
                memToReg    = 1'b1;
                regWriteDec = 1'b1;
            end
            opSw: begin
                aluSrc      = 1'b1;
                memWriteDec = 1'b1;
            end
            opBeq: begin
                aluOp = aluSub;                        // Zero flag compares rs and rt
                beq   = 1'b1;
            end
            opBne: begin
                aluOp = aluSub;
                bne   = 1'b1;
            end
            opJ:     jump = 1'b1;
            default: ;                                 // Undefined opcode, nothing written
        endcase
    end

    assign writeReg = regDst ? instr.rType.rd : instr.rType.rt;

    assign regWrite = regWriteDec & running;
    assign memWrite = memWriteDec & running;
    assign memRead  = memReadDec & running;

    // Data memory sees at most one access per cycle
    always_comb begin
        memExclusive: assert (!(memWrite && memRead))
            else $error("memWrite and memRead both high");
    end

endmodule

`default_nettype wire

// ==== logic/registerFile.sv ====
`default_nettype none

module registerFile
    import isaPkg::*;
(
    input  logic    Clk,
    input  logic    arstN,
    input  regIdx_t rsIdx,
    input  regIdx_t rtIdx,
    input  regIdx_t writeReg,
    input  logic    regWrite,                          // Already gated by running
    input  logic    memToReg,
    input  word_t   aluResult,
    input  word_t   memData,                           // Load data from data memory
    output word_t   rsData,
    output word_t   rtData
);

    word_t regs [32];
    word_t writeData;

    assign writeData = memToReg ? memData : aluResult; // Write-back select

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && writeReg != '0) begin // r0 ignores writes
            regs[writeReg] <= writeData;
        end
    end

    // Combinational reads, r0 never leaves zero
    assign rsData = regs[rsIdx];
    assign rtData = regs[rtIdx];

endmodule

`default_nettype wire

// ==== logic/cpuTop.sv ====
`default_nettype none

module cpuTop
    import isaPkg::*;
(
    input  logic   Clk,
    input  logic   arstN,
    output word_t  instrAddr,                          // Fetch address, same-cycle reply
    input  instr_t instr,
    output word_t  dataAddr,
    output word_t  dataWrData,
    output logic   dataWe,                             // Written at next rising edge
    output logic   dataRe,
    input  word_t  dataRdData                          // Valid while dataRe is high
);

    logic    running;
    logic    regWrite;
    logic    memToReg;
    logic    aluSrc;
    logic    beq;
    logic    bne;
    logic    jump;
    logic    aluZero;
    aluPkg::aluOp_t aluOp;
    regIdx_t writeReg;
    word_t   rsData;

    programCounter pc_i (
        .Clk     (Clk),
        .arstN   (arstN),
        .instr   (instr),
        .aluZero (aluZero),
        .beq     (beq),
        .bne     (bne),
        .jump    (jump),
        .pc      (instrAddr),                          // PC goes straight to fetch
        .running (running)
    );

    controlDecoder dec_i (
        .instr    (instr),
        .running  (running),
        .regWrite (regWrite),
        .memToReg (memToReg),
        .memWrite (dataWe),
        .memRead  (dataRe),
        .aluSrc   (aluSrc),
        .beq      (beq),
        .bne      (bne),
        .jump     (jump),
        .aluOp    (aluOp),
        .writeReg (writeReg)
    );

    registerFile rf_i (
        .Clk       (Clk),
        .arstN     (arstN),
        .rsIdx     (instr.rType.rs),
        .rtIdx     (instr.rType.rt),
        .writeReg  (writeReg),
        .regWrite  (regWrite),
        .memToReg  (memToReg),
        .aluResult (dataAddr),                         // ALU result doubles as address
        .memData   (dataRdData),
        .rsData    (rsData),
        .rtData    (dataWrData)                        // rt is the store data
    );

    executeUnit ex_i (
        .rsData    (rsData),
        .rtData    (dataWrData),
        .instr     (instr),
        .aluSrc    (aluSrc),
        .aluOp     (aluOp),
        .aluResult (dataAddr),
        .aluZero   (aluZero)
    );

endmodule

`default_nettype wire

// ==== sim/tbCpu.sv ====
`default_nettype none

module tbCpu
    import isaPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    progLen       = 200;             // Instructions incl. final self-jump
    localparam int    memWords      = 256;             // 1 KB per memory
    localparam int    resetCycles   = 4;
    localparam int    tailCycles    = 4;               // Cycles parked on the final jump
    localparam int    timeoutCycles = 2 * progLen + 20;
    localparam word_t lastAddr      = word_t'((progLen - 1) * 4);

    logic   Clk;
    logic   arstN;
    word_t  instrAddr;
    instr_t instr;
    word_t  dataAddr;
    word_t  dataWrData;
    logic   dataWe;
    logic   dataRe;
    word_t  dataRdData;

    instr_t      imem [memWords];                      // Program
    word_t       dmem [memWords];                      // Data seen by the DUT
    word_t       modelMem [memWords];                  // Reference copy of data memory
    word_t       modelRegs [32];
    word_t       modelPc;
    logic [31:0] rngState;
    int          errorCount;
    int          checkCount;
    int          cycleCount = 0;
    int          tail;

    cpuTop dut_i (
        .Clk        (Clk),
        .arstN      (arstN),
        .instrAddr  (instrAddr),
        .instr      (instr),
        .dataAddr   (dataAddr),
        .dataWrData (dataWrData),
        .dataWe     (dataWe),
        .dataRe     (dataRe),
        .dataRdData (dataRdData)
    );

    // Same-cycle replies, only the low address bits decode
    assign instr      = imem[instrAddr[9:2]];
    assign dataRdData = dataRe ? dmem[dataAddr[9:2]] : '0;

    always @(posedge Clk) begin
        if (dataWe) begin
            dmem[dataAddr[9:2]] <= dataWrData;         // Store lands at the retiring edge
        end
    end

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;                         // 4 ns period
    end

    always @(posedge Clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > timeoutCycles) begin
            $display("Timeout: program did not park on its final jump within %0d cycles",
                     timeoutCycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    function automatic word_t fillWord(input int idx);
        word_t a;
        a = word_t'(idx) << 2;                         // Byte address of the word
        return (a * 32'h9E3779B1) ^ {a[15:0], ~a[15:0]};
    endfunction

    function automatic word_t signExt(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic checkWord(input word_t got, input word_t exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] %0t: %s got %08h expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic checkFetch(input word_t got, input word_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] %0t: instrAddr got %08h expected %08h", $time, got, exp);
        end
    endtask

    task automatic checkLevel(input logic got, input logic exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic initMemories();
        for (int i = 0; i < memWords; i++) begin
            imem[i]     = {opJ, 26'(i)};               // Spare words jump to themselves
            dmem[i]     <= fillWord(i);
            modelMem[i] = fillWord(i);
        end
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
    endtask

    // Random mix over r0..r7 so results feed later stores and branches
    task automatic buildProgram();
        instr_t      w;
        int          kind;
        int          span;
        logic [31:0] r;
        for (int k = 0; k < progLen - 1; k++) begin
            kind = int'(nextRand() % 16);
            r    = nextRand();
            span = (progLen - 1 - k < 8) ? progLen - 1 - k : 8; // Targets stay in program
            w    = '0;
            w.rType.rs = regIdx_t'(nextRand() % 8);
            w.rType.rt = regIdx_t'(nextRand() % 8);
            w.rType.rd = regIdx_t'(nextRand() % 8);
            case (kind)
                0: w.rType.funct = fnAdd;              // Opcode zero is R-type
                1: w.rType.funct = fnSub;
                2: w.rType.funct = fnAnd;
                3: w.rType.funct = fnOr;
                4: w.rType.funct = fnSlt;
                5: w.rType.funct = 6'b100001;          // addu, not in the subset
                6, 7, 8, 9, 10, 11: begin
                    w.iType.opcode = (kind < 8) ? opAddi : (kind < 10) ? opLw : opSw;
                    w.iType.imm    = r[15:0];
                end
                12, 13: begin
                    w.iType.opcode = (kind == 12) ? opBeq : opBne;
                    w.iType.imm    = 16'(r % span); // Forward only
                end
                14: begin
                    w.jType.opcode = opJ;
                    w.jType.target = 26'(k + 1 + int'(r % span));
                end
                default: begin
                    w.iType.opcode = 6'b001101;        // ori, undefined here
                    w.iType.imm    = r[15:0];
                end
            endcase
            imem[k] = w;
        end
        imem[progLen-1] = {opJ, 26'(progLen - 1)};     // Park on itself
    endtask

    // Outputs expected while the instruction at modelPc is being executed
    task automatic checkCycle();
        instr_t w;
        word_t  addr;
        w    = imem[modelPc[9:2]];
        addr = modelRegs[w.iType.rs] + signExt(w.iType.imm);
        checkFetch(instrAddr, modelPc);
        checkLevel(dataWe, w.iType.opcode == opSw, "dataWe");
        checkLevel(dataRe, w.iType.opcode == opLw, "dataRe");
        if (dataWe && dataRe) begin
            errorCount++;
            $display("Error at %0t: dataWe and dataRe are high in the same cycle", $time);
        end
        if (w.iType.opcode == opLw || w.iType.opcode == opSw) begin
            checkWord(dataAddr, addr, "dataAddr");
        end
        if (w.iType.opcode == opSw) begin
            checkWord(dataWrData, modelRegs[w.iType.rt], "store data");
        end
    endtask

    task automatic stepModel();
        instr_t  w;
        word_t   a;
        word_t   b;
        word_t   imm;
        word_t   addr;
        word_t   res;
        word_t   pcPlus4;
        word_t   pcNext;
        logic    wr;
        regIdx_t dst;
        w       = imem[modelPc[9:2]];
        a       = modelRegs[w.rType.rs];
        b       = modelRegs[w.rType.rt];
        imm     = signExt(w.iType.imm);
        addr    = a + imm;
        pcPlus4 = modelPc + 32'd4;
        pcNext  = pcPlus4;
        wr      = 1'b0;
        dst     = w.iType.rt;                          // I-type destination
        res     = '0;
        case (w.rType.opcode)
            opR: begin
                dst = w.rType.rd;
                wr  = 1'b1;
                case (w.rType.funct)
                    fnAdd:   res = a + b;
                    fnSub:   res = a - b;
                    fnAnd:   res = a & b;
                    fnOr:    res = a | b;
                    fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;                // Unknown funct is a no-op
                endcase
            end
            opAddi: begin
                res = addr;
                wr  = 1'b1;
            end
            opLw: begin
                res = modelMem[addr[9:2]];
                wr  = 1'b1;
            end
            opSw:    modelMem[addr[9:2]] = b;
            opBeq:   pcNext = (a == b) ? pcPlus4 + (imm << 2) : pcPlus4;
            opBne:   pcNext = (a != b) ? pcPlus4 + (imm << 2) : pcPlus4;
            opJ:     pcNext = {pcPlus4[31:28], w.jType.target, 2'b00};
            default: ;
        endcase
        if (wr && dst != '0) begin
            modelRegs[dst] = res;                      // r0 stays zero
        end
        modelPc = pcNext;
    endtask

    initial begin
        arstN      = 1'b0;
        errorCount = 0;
        checkCount = 0;
        modelPc    = '0;
        rngState   = 32'h330881b5;
        initMemories();
        buildProgram();
        for (int i = 0; i < resetCycles; i++) begin
            @(negedge Clk);
            checkLevel(dataWe, 1'b0, "dataWe in reset");
            checkLevel(dataRe, 1'b0, "dataRe in reset");
            checkFetch(instrAddr, '0);
        end
        @(posedge Clk);
        arstN <= 1'b1;
        @(negedge Clk);                                // Running still low here
        checkLevel(dataWe, 1'b0, "dataWe after reset");
        checkLevel(dataRe, 1'b0, "dataRe after reset");
        checkFetch(instrAddr, '0);
        tail = 0;
        while (tail < tailCycles) begin
            @(negedge Clk);
            checkCycle();
            stepModel();
            if (modelPc == lastAddr) begin
                tail++;
            end
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/isaPkg.sv
logic/aluPkg.sv
logic/aluSlice4.sv
logic/executeUnit.sv
logic/programCounter.sv
logic/controlDecoder.sv
logic/registerFile.sv
logic/cpuTop.sv
sim/tbCpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbCpu
RTL_TOP   ?= cpuTop
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "Simulation ended without result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
